//--- compile.f
+incdir+.
fifo_regs_pkg.sv
sram_pkg.sv
fifo_rd_if.sv
sram_fifo_regs.sv
sram_fifo_ptrs.sv
sram_fifo_reader.sv
sram_fifo_level.sv
sram_fifo_top.sv
tb_sram_model.sv
tb_sram_fifo_asserts.sv
tb_sram_fifo.sv

//--- fifo_rd_if.sv
// pointer block to read sequencer link, SRAM read grant and read data
`timescale 1ns/1ps
`default_nettype none

interface fifo_rd_if import sram_pkg::*; ();

    logic       empty;     // SRAM holds no half-word
    logic       read_sram; // reader owns the SRAM this cycle
    sram_word_u rdata;     // data on the SRAM pins
    logic       staged;    // prefetched half-word not yet fully sent

    modport ptrs (
        output empty,
        output rdata,
        input  read_sram,
        input  staged
    );

    modport reader (
        input  empty,
        input  rdata,
        output read_sram,
        output staged
    );

endinterface

`default_nettype wire

//--- fifo_regs_pkg.sv
// register map and threshold types for the bus side of the SRAM FIFO
`default_nettype none

`include "sram_fifo_params.svh"

package fifo_regs_pkg;

    // write side and read side share addresses 1 and 2
    typedef enum logic [`BUS_AW-1:0] {
        REG_SOFT_RST  = 0, // any write flushes the FIFO
        REG_LEVEL_HI  = 1, // near-full threshold / fill bits 23:16
        REG_LEVEL_MID = 2, // near-empty threshold / fill bits 15:8
        REG_LEVEL_LO  = 3, // fill bits 7:0
        REG_ERR_CNT   = 4  // saturating read-error count
    } reg_addr_e;

    // threshold in 1/256 of depth
    typedef logic [`THRESH_W-1:0] thresh_t;

    localparam thresh_t NEAR_FULL_TH_DEF  = thresh_t'(255 * `NEAR_FULL_PCT / 100);
    localparam thresh_t NEAR_EMPTY_TH_DEF = thresh_t'(255 * `NEAR_EMPTY_PCT / 100);

endpackage

`default_nettype wire

//--- sram_fifo_level.sv
// near-full flag of the SRAM FIFO with hysteresis between two thresholds
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_params.svh"

module sram_fifo_level import sram_pkg::*; import fifo_regs_pkg::*; #(
    parameter int DEPTH = `SRAM_DEPTH
) (
    input  wire     bus_clk,
    input  wire     rst,
    input  fill_t   fill_count,
    input  thresh_t near_full_th,
    input  thresh_t near_empty_th,
    output logic    near_full
);

    localparam int MARK_W = `FILL_W + `THRESH_W;

    typedef logic [MARK_W-1:0] mark_t;

    mark_t full_mark;
    mark_t empty_mark;
    mark_t fill_ext;

    // multiply first so small depths keep their resolution
    function automatic mark_t scale_th(input thresh_t th);
        return (mark_t'(th) * mark_t'(DEPTH)) >> `THRESH_W;
    endfunction

    assign full_mark  = scale_th(near_full_th);
    assign empty_mark = scale_th(near_empty_th);
    assign fill_ext   = mark_t'(fill_count);

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            near_full <= 1'b0;
        end else if (fill_ext >= full_mark || near_full_th == '0) begin
            near_full <= 1'b1;
        end else if (fill_ext <= empty_mark) begin
            near_full <= 1'b0; // zero fill lands here too
        end
    end

endmodule

`default_nettype wire

//--- sram_fifo_params.svh
// default sizes and threshold percentages for the SRAM-backed byte FIFO
`ifndef SRAM_FIFO_PARAMS_SVH
`define SRAM_FIFO_PARAMS_SVH

// buffer depth in 16-bit half-words
`define SRAM_DEPTH 1048576

// external SRAM address and data widths
`define SRAM_AW 20
`define SRAM_DW 16

// reset values of the level thresholds, in percent of depth
`define NEAR_FULL_PCT 95
`define NEAR_EMPTY_PCT 5

// fill count in half-words, one bit wider than the address
`define FILL_W 21

// register bus address width and threshold width
`define BUS_AW 16
`define THRESH_W 8

`endif

//--- sram_fifo_ptrs.sv
// circular buffer pointers, write arbitration and SRAM pin drive of the SRAM FIFO
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_params.svh"

module sram_fifo_ptrs import sram_pkg::*; #(
    parameter int DEPTH = `SRAM_DEPTH
) (
    input  wire                 bus_clk,
    input  wire                 rst,
    input  wire                 fifo_empty_in,
    input  wire [31:0]          fifo_data,
    output logic                fifo_read_next,
    output sram_addr_t          sram_a,
    inout  wire [`SRAM_DW-1:0]  sram_io,
    output logic                sram_oe_b,
    output logic                sram_we_b,
    output logic                full,
    output fill_t               fill_count,
    fifo_rd_if.ptrs             rd
);

    sram_addr_t          wr_ptr;
    sram_addr_t          rd_ptr;
    sram_addr_t          wr_next;
    sram_addr_t          rd_next;
    logic                write_sram;
    logic [`SRAM_DW-1:0] wdata;
    fill_t               ptr_diff;

    // wraps at DEPTH, which need not be a power of two
    function automatic sram_addr_t ptr_inc(input sram_addr_t p);
        if (p == sram_addr_t'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign wr_next = ptr_inc(wr_ptr);
    assign rd_next = ptr_inc(rd_ptr);

    assign rd.empty = (wr_ptr == rd_ptr);
    assign rd.rdata = sram_io;

    // reader has priority on the SRAM
    assign write_sram     = !fifo_empty_in && !full && !rd.read_sram;
    assign fifo_read_next = write_sram && wr_ptr[0]; // pop after the low half

    // even location takes the high half of the word
    assign wdata = wr_ptr[0] ? fifo_data[15:0] : fifo_data[31:16];

    assign sram_io   = write_sram ? wdata : 'z;
    assign sram_a    = rd.read_sram ? rd_ptr : wr_ptr;
    assign sram_oe_b = !rd.read_sram;
    assign sram_we_b = !write_sram; // low for the whole write cycle

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
        end else if (rd.read_sram) begin
            rd_ptr <= rd_next;
            full   <= 1'b0; // a read always frees a slot
        end else if (write_sram) begin
            wr_ptr <= wr_next;
            full   <= (ptr_inc(wr_next) == rd_ptr); // full after this write
        end
    end

    // occupied locations between the pointers
    always_comb begin
        if (wr_ptr >= rd_ptr) begin
            ptr_diff = fill_t'(wr_ptr) - fill_t'(rd_ptr);
        end else begin
            ptr_diff = fill_t'(DEPTH) + fill_t'(wr_ptr) - fill_t'(rd_ptr);
        end
    end

    // staged half-word has already left the SRAM but is still owed
    always_ff @(posedge bus_clk) begin
        if (rst) begin
            fill_count <= '0;
        end else begin
            fill_count <= ptr_diff + fill_t'(rd.staged);
        end
    end

endmodule

`default_nettype wire

//--- sram_fifo_reader.sv
// USB-side read sequencer with half-word prefetch, byte toggle and error count
`timescale 1ns/1ps
`default_nettype none

module sram_fifo_reader import sram_pkg::*; (
    input  wire         bus_clk,
    input  wire         rst,
    input  wire         usb_read,
    output logic [7:0]  usb_data,
    output logic [7:0]  err_count,
    output logic        data_avail,
    fifo_rd_if.reader   rd
);

    typedef enum logic [1:0] {
        RD_TRY,  // wait for SRAM data
        RD_READ, // one SRAM read cycle
        RD_HOLD  // half-word staged for the host
    } rd_state_e;

    rd_state_e  state_q;
    rd_state_e  state_d;
    sram_word_u data_q;
    logic       byte_sel; // 0 hi byte, 1 lo byte
    logic       take_dly; // strobe that consumed a byte, one cycle late

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_TRY: begin
                if (!rd.empty) begin
                    state_d = RD_READ;
                end
            end
            RD_READ: state_d = RD_HOLD;
            RD_HOLD: begin
                // lo byte taken, refill or go idle
                if (usb_read && byte_sel) begin
                    state_d = rd.empty ? RD_TRY : RD_READ;
                end
            end
            default: state_d = RD_TRY;
        endcase
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            state_q  <= RD_TRY;
            take_dly <= 1'b0;
            byte_sel <= 1'b0;
        end else begin
            state_q  <= state_d;
            take_dly <= usb_read && rd.staged;
            if (rd.read_sram) begin
                byte_sel <= 1'b0; // new half-word starts at hi
            end else if (take_dly) begin
                byte_sel <= !byte_sel;
            end
        end
    end

    assign rd.read_sram = (state_q == RD_READ);
    assign rd.staged    = (state_q == RD_HOLD);
    assign data_avail   = rd.staged;

    always_ff @(posedge bus_clk) begin
        if (rd.read_sram) begin
            data_q <= rd.rdata;
        end
    end

    assign usb_data = byte_sel ? data_q.bytes.lo : data_q.bytes.hi;

    // strobes with nothing staged, saturating
    always_ff @(posedge bus_clk) begin
        if (rst) begin
            err_count <= 8'h00;
        end else if (usb_read && !rd.staged && err_count != 8'hff) begin
            err_count <= err_count + 8'h01;
        end
    end

endmodule

`default_nettype wire

//--- sram_fifo_regs.sv
// bus register file of the SRAM FIFO with soft reset, thresholds and status readback
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_params.svh"

module sram_fifo_regs import fifo_regs_pkg::*; (
    input  wire                bus_clk,
    input  wire                rst,
    input  wire [`BUS_AW-1:0]  bus_add,
    input  wire [7:0]          bus_data_in,
    input  wire                bus_rd,
    input  wire                bus_wr,
    input  wire [`FILL_W-1:0]  fill_count,
    input  wire [7:0]          err_count,
    output logic [7:0]         bus_data_out,
    output logic               fifo_rst,
    output thresh_t            near_full_th,
    output thresh_t            near_empty_th
);

    logic        soft_rst_q;
    logic [23:0] fill_ext; // fill count spread over three bytes

    assign fill_ext = 24'(fill_count);

    // soft reset fires the cycle after the write
    always_ff @(posedge bus_clk) begin
        if (rst) begin
            soft_rst_q <= 1'b0;
        end else begin
            soft_rst_q <= bus_wr && (bus_add == REG_SOFT_RST);
        end
    end

    assign fifo_rst = rst | soft_rst_q;

    always_ff @(posedge bus_clk) begin
        if (fifo_rst) begin
            near_full_th  <= NEAR_FULL_TH_DEF;
            near_empty_th <= NEAR_EMPTY_TH_DEF;
        end else if (bus_wr) begin
            case (bus_add)
                REG_LEVEL_HI:  near_full_th  <= bus_data_in;
                REG_LEVEL_MID: near_empty_th <= bus_data_in;
                default: ; // other addresses are read only
            endcase
        end
    end

    // readback valid one cycle after the strobe
    always_ff @(posedge bus_clk) begin
        if (bus_rd) begin
            case (bus_add)
                REG_LEVEL_HI:  bus_data_out <= fill_ext[23:16];
                REG_LEVEL_MID: bus_data_out <= fill_ext[15:8];
                REG_LEVEL_LO:  bus_data_out <= fill_ext[7:0];
                REG_ERR_CNT:   bus_data_out <= err_count;
                default:       bus_data_out <= 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sram_fifo_top.sv
// SRAM-backed byte FIFO top level joining registers, pointers, reader and level flag
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_params.svh"

module sram_fifo_top #(
    parameter int DEPTH = `SRAM_DEPTH
) (
    input  wire                 BUS_CLK,
    input  wire                 RST,

    input  wire [`BUS_AW-1:0]   bus_add,
    input  wire [7:0]           bus_data_in,
    input  wire                 bus_rd,
    input  wire                 bus_wr,
    output logic [7:0]          bus_data_out,

    output logic [`SRAM_AW-1:0] sram_a,
    inout  wire [`SRAM_DW-1:0]  sram_io,
    output logic                sram_oe_b,
    output logic                sram_we_b,

    input  wire                 usb_read,
    output logic [7:0]          usb_data,

    output logic                fifo_read_next,
    input  wire                 fifo_empty_in,
    input  wire [31:0]          fifo_data,

    output logic                fifo_not_empty,
    output logic                fifo_full,
    output logic                fifo_near_full,
    output logic                fifo_read_error
);

    logic                 fifo_rst;      // RST or soft reset
    logic [`FILL_W-1:0]   fill_count;
    logic [`THRESH_W-1:0] near_full_th;
    logic [`THRESH_W-1:0] near_empty_th;
    logic [7:0]           err_count;

    fifo_rd_if rd_bus ();

    sram_fifo_regs u_regs (
        .bus_clk       (BUS_CLK),
        .rst           (RST),
        .bus_add       (bus_add),
        .bus_data_in   (bus_data_in),
        .bus_rd        (bus_rd),
        .bus_wr        (bus_wr),
        .fill_count    (fill_count),
        .err_count     (err_count),
        .bus_data_out  (bus_data_out),
        .fifo_rst      (fifo_rst),
        .near_full_th  (near_full_th),
        .near_empty_th (near_empty_th)
    );

    sram_fifo_ptrs #(
        .DEPTH (DEPTH)
    ) u_ptrs (
        .bus_clk        (BUS_CLK),
        .rst            (fifo_rst),
        .fifo_empty_in  (fifo_empty_in),
        .fifo_data      (fifo_data),
        .fifo_read_next (fifo_read_next),
        .sram_a         (sram_a),
        .sram_io        (sram_io),
        .sram_oe_b      (sram_oe_b),
        .sram_we_b      (sram_we_b),
        .full           (fifo_full),
        .fill_count     (fill_count),
        .rd             (rd_bus)
    );

    sram_fifo_reader u_reader (
        .bus_clk    (BUS_CLK),
        .rst        (fifo_rst),
        .usb_read   (usb_read),
        .usb_data   (usb_data),
        .err_count  (err_count),
        .data_avail (fifo_not_empty),
        .rd         (rd_bus)
    );

    sram_fifo_level #(
        .DEPTH (DEPTH)
    ) u_level (
        .bus_clk       (BUS_CLK),
        .rst           (fifo_rst),
        .fill_count    (fill_count),
        .near_full_th  (near_full_th),
        .near_empty_th (near_empty_th),
        .near_full     (fifo_near_full)
    );

    assign fifo_read_error = (err_count != 8'h00);

endmodule

`default_nettype wire

//--- sram_pkg.sv
// SRAM address, half-word and fill count types for the SRAM FIFO
`default_nettype none

`include "sram_fifo_params.svh"

package sram_pkg;

    typedef logic [`SRAM_AW-1:0] sram_addr_t;

    // high byte leaves the FIFO first
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } sram_bytes_t;

    // one SRAM location, stored as a word and sent as two bytes
    typedef union packed {
        logic [`SRAM_DW-1:0] half;
        sram_bytes_t         bytes;
    } sram_word_u;

    // half-words held in SRAM plus the staged one
    typedef logic [`FILL_W-1:0] fill_t;

endpackage

`default_nettype wire

//--- tb_sram_fifo.sv
// testbench for the SRAM-backed byte FIFO with upstream source, USB host and bus driver
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_params.svh"

module tb_sram_fifo import sram_pkg::*, fifo_regs_pkg::*; ();

    localparam int DEPTH       = 64;
    localparam int SEED        = 32'h7f64_cfa2;
    localparam int T1_WORDS    = 10;
    localparam int T2_WORDS    = 40;
    localparam int T3_STEPS [7] = '{8, 8, 6, -8, -6, 8, -16}; // words pushed or drained
    localparam int T3_WORDS    = 30;
    localparam int T4_WORDS    = 4;
    localparam int T5_FIRST    = 12;
    localparam int T5_MID      = 22;
    localparam int T5_LAST     = 8;
    localparam int T5_WORDS    = T5_FIRST + T5_MID + T5_LAST;
    localparam int PUSHED_HW   = 2 * (T1_WORDS + T2_WORDS + T3_WORDS + T4_WORDS + T5_WORDS);
    localparam int CYCLE_LIMIT = 64 * PUSHED_HW + 2000;

    logic                 BUS_CLK;
    logic                 RST;
    logic [`BUS_AW-1:0]   bus_add;
    logic [7:0]           bus_data_in;
    logic                 bus_rd;
    logic                 bus_wr;
    logic [7:0]           bus_data_out;
    logic [`SRAM_AW-1:0]  sram_a;
    wire  [`SRAM_DW-1:0]  sram_io;
    logic                 sram_oe_b;
    logic                 sram_we_b;
    logic                 usb_read;
    logic [7:0]           usb_data;
    logic                 fifo_read_next;
    logic                 fifo_empty_in;
    logic [31:0]          fifo_data;
    logic                 fifo_not_empty;
    logic                 fifo_full;
    logic                 fifo_near_full;
    logic                 fifo_read_error;

    logic [31:0] src_q [$]; // upstream words not yet popped
    logic [7:0]  exp_q [$]; // bytes the host should see next
    int          pop_count;
    int          hw_in;
    int          bytes_out;
    int          n_checks;
    int          n_errors;
    int          test_base;
    int          cycles;

    sram_fifo_top #(
        .DEPTH (DEPTH)
    ) DUT (
        .BUS_CLK         (BUS_CLK),
        .RST             (RST),
        .bus_add         (bus_add),
        .bus_data_in     (bus_data_in),
        .bus_rd          (bus_rd),
        .bus_wr          (bus_wr),
        .bus_data_out    (bus_data_out),
        .sram_a          (sram_a),
        .sram_io         (sram_io),
        .sram_oe_b       (sram_oe_b),
        .sram_we_b       (sram_we_b),
        .usb_read        (usb_read),
        .usb_data        (usb_data),
        .fifo_read_next  (fifo_read_next),
        .fifo_empty_in   (fifo_empty_in),
        .fifo_data       (fifo_data),
        .fifo_not_empty  (fifo_not_empty),
        .fifo_full       (fifo_full),
        .fifo_near_full  (fifo_near_full),
        .fifo_read_error (fifo_read_error)
    );

    tb_sram_model #(
        .DEPTH (DEPTH)
    ) u_sram (
        .clk  (BUS_CLK),
        .addr (sram_a),
        .data (sram_io),
        .oe_b (sram_oe_b),
        .we_b (sram_we_b)
    );

    bind sram_fifo_ptrs tb_sram_fifo_asserts #(.DEPTH(DEPTH)) u_asserts (
        .bus_clk        (bus_clk),
        .rst            (rst),
        .fifo_empty_in  (fifo_empty_in),
        .fifo_read_next (fifo_read_next),
        .sram_a         (sram_a),
        .sram_oe_b      (sram_oe_b),
        .sram_we_b      (sram_we_b)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #20 BUS_CLK = ~BUS_CLK;
    end

    // byte idx of a word in send order, 31:24 first
    function automatic logic [7:0] word_byte(input logic [31:0] w, input int idx);
        return w[31 - 8 * idx -: 8];
    endfunction

    // near-full rule with hysteresis, marks in 1/256 of depth
    function automatic logic near_full_ref(input fill_t fill, input thresh_t full_th,
                                           input thresh_t empty_th, input logic prev);
        int full_mark;
        int empty_mark;
        full_mark  = int'(full_th) * DEPTH / 256;
        empty_mark = int'(empty_th) * DEPTH / 256;
        if (full_th == 0 || int'(fill) >= full_mark) begin
            return 1'b1;
        end
        if (int'(fill) <= empty_mark) begin
            return 1'b0;
        end
        return prev;
    endfunction

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH t=%0t %s: got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input string what, input logic [7:0] got, input logic [7:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH t=%0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    // upstream FWFT source, head word pops on the second half
    always @(posedge BUS_CLK) begin
        if (fifo_read_next && src_q.size() > 0) begin
            void'(src_q.pop_front());
            pop_count++;
        end
        fifo_empty_in <= (src_q.size() == 0);
        fifo_data     <= (src_q.size() > 0) ? src_q[0] : 32'h0;
    end

    // compare every byte the host takes
    always @(posedge BUS_CLK) begin
        if (!RST && usb_read && fifo_not_empty) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("t=%0t host took a byte while none was expected", $time);
            end else begin
                check_byte("usb byte", usb_data, exp_q.pop_front());
            end
            bytes_out++;
        end
    end

    task automatic push_words(input int n);
        logic [31:0] w;
        @(negedge BUS_CLK); // away from the source's pop edge
        for (int i = 0; i < n; i++) begin
            w = $urandom();
            src_q.push_back(w);
            hw_in += 2;
            for (int b = 0; b < 4; b++) begin
                exp_q.push_back(word_byte(w, b));
            end
        end
    endtask

    task automatic wait_source_empty();
        while (src_q.size() != 0) begin
            @(negedge BUS_CLK);
        end
    endtask

    // host strobes spaced 5 cycles apart
    task automatic usb_strobe(input int n, input bit wait_data);
        for (int i = 0; i < n; i++) begin
            @(posedge BUS_CLK);
            while (wait_data && !fifo_not_empty) begin
                @(posedge BUS_CLK);
            end
            usb_read <= 1'b1;
            @(posedge BUS_CLK);
            usb_read <= 1'b0;
            repeat (3) @(posedge BUS_CLK);
        end
    endtask

    task automatic bus_write(input logic [`BUS_AW-1:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr      <= 1'b0;
    endtask

    task automatic bus_read(input logic [`BUS_AW-1:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd  <= 1'b0;
        @(posedge BUS_CLK);
        data = bus_data_out; // registered one cycle after the strobe
    endtask

    task automatic check_level(input thresh_t full_th, input thresh_t empty_th,
                               inout logic prev_nf);
        fill_t      exp_fill;
        logic [7:0] rdata;
        repeat (4) @(negedge BUS_CLK); // fill count, then flag
        exp_fill = fill_t'(hw_in - bytes_out / 2); // staged half-word still counts
        prev_nf  = near_full_ref(exp_fill, full_th, empty_th, prev_nf);
        check_flag("fifo_near_full", fifo_near_full, prev_nf);
        bus_read(REG_LEVEL_LO, rdata);
        check_reg("fill 7:0", rdata, exp_fill[7:0]);
    endtask

    task automatic expect_drained();
        @(negedge BUS_CLK);
        n_checks++;
        if (exp_q.size() != 0 || fifo_not_empty) begin
            n_errors++;
            $display("t=%0t FIFO not drained, %0d bytes still expected", $time, exp_q.size());
        end
    endtask

    task automatic end_test(input string name);
        if (n_errors == test_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n_errors - test_base);
        end
        test_base = n_errors;
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge BUS_CLK);
            cycles++;
        end
        $display("timeout after %0d cycles, test sequence did not complete", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        thresh_t    full_th;
        thresh_t    empty_th;
        logic [7:0] rdata;
        logic       prev_nf;
        int         base;
        void'($urandom(SEED));
        RST           = 1'b1;
        bus_add       = '0;
        bus_data_in   = 8'h00;
        bus_rd        = 1'b0;
        bus_wr        = 1'b0;
        usb_read      = 1'b0;
        fifo_empty_in = 1'b1;
        fifo_data     = 32'h0;
        pop_count     = 0;
        hw_in         = 0;
        bytes_out     = 0;
        n_checks      = 0;
        n_errors      = 0;
        test_base     = 0;
        repeat (16) @(posedge BUS_CLK);
        RST <= 1'b0;
        repeat (4) @(posedge BUS_CLK);

        push_words(T1_WORDS);
        usb_strobe(4 * T1_WORDS, 1'b1);
        expect_drained();
        end_test("byte order");

        // DEPTH-1 locations in SRAM plus one staged half-word
        base = pop_count;
        push_words(T2_WORDS);
        while (!fifo_full) begin
            @(negedge BUS_CLK);
        end
        repeat (20) @(negedge BUS_CLK); // source must stay stalled
        check_flag("fifo_full", fifo_full, 1'b1);
        check_reg("words accepted", 8'(pop_count - base), 8'(DEPTH / 2));
        bus_read(REG_LEVEL_LO, rdata);
        check_reg("fill 7:0 when full", rdata, 8'(DEPTH));
        bus_read(REG_LEVEL_MID, rdata);
        check_reg("fill 15:8 when full", rdata, 8'(DEPTH >> 8));
        usb_strobe(4 * T2_WORDS, 1'b1); // held-back words follow the accepted ones
        expect_drained();
        end_test("full and back-pressure");

        full_th  = 8'd160; // mark 40 half-words
        empty_th = 8'd64;  // mark 16
        bus_write(REG_LEVEL_HI, full_th);
        bus_write(REG_LEVEL_MID, empty_th);
        prev_nf = 1'b0;
        foreach (T3_STEPS[i]) begin
            if (T3_STEPS[i] > 0) begin
                push_words(T3_STEPS[i]);
                wait_source_empty();
            end else begin
                usb_strobe(-4 * T3_STEPS[i], 1'b1);
            end
            check_level(full_th, empty_th, prev_nf);
        end
        expect_drained();
        end_test("near-full hysteresis");

        usb_strobe(3, 1'b0);
        bus_read(REG_ERR_CNT, rdata);
        check_reg("error count", rdata, 8'd3);
        @(negedge BUS_CLK);
        check_flag("fifo_read_error", fifo_read_error, 1'b1);
        push_words(T4_WORDS);
        wait_source_empty();
        usb_strobe(4 * T4_WORDS, 1'b1);
        expect_drained();
        end_test("read errors");

        push_words(T5_FIRST);
        wait_source_empty();
        usb_strobe(9, 1'b1); // two words and one hi byte
        bus_write(REG_SOFT_RST, 8'h00);
        exp_q.delete();
        hw_in     = 0;
        bytes_out = 0;
        repeat (4) @(negedge BUS_CLK);
        check_flag("fifo_not_empty after soft reset", fifo_not_empty, 1'b0);
        check_flag("fifo_read_error after soft reset", fifo_read_error, 1'b0);
        bus_read(REG_LEVEL_LO, rdata);
        check_reg("fill 7:0 after soft reset", rdata, 8'd0);
        bus_read(REG_LEVEL_MID, rdata);
        check_reg("fill 15:8 after soft reset", rdata, 8'd0);
        bus_read(REG_ERR_CNT, rdata);
        check_reg("error count after soft reset", rdata, 8'd0);
        full_th  = thresh_t'(255 * `NEAR_FULL_PCT / 100);
        empty_th = thresh_t'(255 * `NEAR_EMPTY_PCT / 100);
        prev_nf  = 1'b0;
        push_words(T5_MID); // near-full only under the old thresholds
        wait_source_empty();
        check_level(full_th, empty_th, prev_nf);
        push_words(T5_LAST);
        wait_source_empty();
        check_level(full_th, empty_th, prev_nf);
        usb_strobe(exp_q.size(), 1'b1);
        expect_drained();
        end_test("soft reset");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_sram_fifo_asserts.sv
// bound checks on SRAM pin drive and upstream pops of the FIFO pointer block
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_params.svh"

module tb_sram_fifo_asserts #(
    parameter int DEPTH = `SRAM_DEPTH
) (
    input wire                bus_clk,
    input wire                rst,
    input wire                fifo_empty_in,
    input wire                fifo_read_next,
    input wire [`SRAM_AW-1:0] sram_a,
    input wire                sram_oe_b,
    input wire                sram_we_b
);

    // read and write never share a cycle
    no_rw_overlap: assert property (@(posedge bus_clk) disable iff (rst)
        !(!sram_we_b && !sram_oe_b))
        else $error("SRAM WE and OE low in the same cycle");

    pop_needs_data: assert property (@(posedge bus_clk) disable iff (rst)
        fifo_read_next |-> !fifo_empty_in)
        else $error("upstream pop while the source is empty");

    addr_in_range: assert property (@(posedge bus_clk) disable iff (rst)
        sram_a < DEPTH) // circular buffer wraps at DEPTH
        else $error("SRAM address beyond buffer depth");

endmodule

`default_nettype wire

//--- tb_sram_model.sv
// behavioural asynchronous SRAM with tristate data pins for the FIFO testbench
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_params.svh"

module tb_sram_model #(
    parameter int DEPTH = `SRAM_DEPTH
) (
    input wire                clk,
    input wire [`SRAM_AW-1:0] addr,
    inout wire [`SRAM_DW-1:0] data,
    input wire                oe_b,
    input wire                we_b
);

    typedef logic [`SRAM_DW-1:0] word_t;

    word_t mem [DEPTH];

    // power-up contents folded from every address bit
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = word_t'(i) ^ word_t'(i >> 16) ^ 16'h5a3c;
        end
    end

    // WE may stay low over back-to-back writes, so clk marks where each write cycle ends
    always @(posedge clk) begin
        if (!we_b) begin
            mem[addr] <= data;
        end
    end

    assign data = (!oe_b && we_b) ? mem[addr] : 'z; // chip select tied active

endmodule

`default_nettype wire
